// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_routing_table_reader -f tb.f -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1; cat sim.log
	@if grep -q "Regression failed" sim.log || ! grep -q "Regression passed" sim.log; then \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: tb.f
verilog/routing_pkg.sv
verilog/burst_reader.sv
verilog/table_loader.sv
verilog/lookup_engine.sv
verilog/routing_table_reader.sv
testbench/routing_table_reader_properties.sv
testbench/tb_routing_table_reader.sv

// File: testbench/routing_table_reader_properties.sv
`timescale 1ns/100ps

module routing_table_reader_properties
    import routing_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        load_req,
    input logic        load_ack,
    input logic        host_req,
    input logic        host_ack,
    input logic        host_found,
    input host_entry_t host_entry,
    input logic        path_req,
    input logic        path_ack,
    input path_entry_t path_entry
);

    // ========================================
    // four-phase handshakes
    // ========================================
    load_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(load_ack) |-> load_req)
        else $error("load_ack rose without load_req");

    host_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(host_ack) |-> host_req)
        else $error("host_ack rose without host_req");

    path_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(path_ack) |-> path_req)
        else $error("path_ack rose without path_req");

    // results frozen under ack
    host_result_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (host_ack && $past(host_ack)) |-> ($stable(host_found) && $stable(host_entry)))
        else $error("host result changed while host_ack was high");

    path_result_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (path_ack && $past(path_ack)) |-> $stable(path_entry))
        else $error("path result changed while path_ack was high");

    // one query at a time
    acks_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(host_ack && path_ack))
        else $error("host_ack and path_ack high together");

endmodule

bind routing_table_reader routing_table_reader_properties u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_req   (load_req),
    .load_ack   (load_ack),
    .host_req   (host_req),
    .host_ack   (host_ack),
    .host_found (host_found),
    .host_entry (host_entry),
    .path_req   (path_req),
    .path_ack   (path_ack),
    .path_entry (path_entry)
);

// File: testbench/tb_routing_table_reader.sv
`timescale 1ns/100ps

module tb_routing_table_reader
    import routing_pkg::*;
();

    localparam int ADDR_W      = 16;
    localparam int HOST_IDX_W  = 6;
    localparam int SWITCH_ID_W = 4;
    localparam int ROM_WORDS   = 1 << (ADDR_W - 2);
    localparam int N_PATHS     = 16;
    localparam int LOAD_CYC    = 15 + 4;
    localparam int QUERY_CYC   = ENTRY_WORDS + 4 + 4;
    // reset, three loads, 23 host queries, paths, tie, blocked query
    localparam int TEST_CYC    = 10 + 3 * LOAD_CYC + 23 * QUERY_CYC
                               + N_PATHS * QUERY_CYC + 4 * QUERY_CYC + 8;
    localparam int TIMEOUT_CYC = 2 * TEST_CYC;
    localparam int ACK_LOAD    = 0;
    localparam int ACK_HOST    = 1;
    localparam int ACK_PATH    = 2;

    logic                   clk;
    logic                   rst_n;
    logic [ADDR_W-1:0]      mem_addr;
    logic [WORD_W-1:0]      mem_data;
    logic                   load_req;
    logic                   load_ack;
    logic                   tables_valid;
    logic                   parse_error;
    logic                   host_req;
    logic [HOST_IDX_W-1:0]  host_index;
    logic                   host_ack;
    logic                   host_found;
    host_entry_t            host_entry;
    logic                   path_req;
    logic [SWITCH_ID_W-1:0] src_switch;
    logic [SWITCH_ID_W-1:0] dst_switch;
    logic                   path_ack;
    path_entry_t            path_entry;

    logic [WORD_W-1:0] rom [0:ROM_WORDS-1];
    logic [31:0]       lfsr_state;
    int                host_count;
    int                max_sw;
    int                errors;
    int                checks;
    int                cycles;
    host_entry_t       exp_host_q[$];
    logic              exp_found_q[$];
    path_entry_t       exp_path_q[$];
    host_entry_t       exp_h;
    path_entry_t       exp_p;
    logic              exp_f;
    logic              host_ack_q;
    logic              path_ack_q;

    routing_table_reader #(
        .ADDR_W      (ADDR_W),
        .HOST_IDX_W  (HOST_IDX_W),
        .SWITCH_ID_W (SWITCH_ID_W)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data),
        .load_req     (load_req),
        .load_ack     (load_ack),
        .tables_valid (tables_valid),
        .parse_error  (parse_error),
        .host_req     (host_req),
        .host_index   (host_index),
        .host_ack     (host_ack),
        .host_found   (host_found),
        .host_entry   (host_entry),
        .path_req     (path_req),
        .src_switch   (src_switch),
        .dst_switch   (dst_switch),
        .path_ack     (path_ack),
        .path_entry   (path_entry)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // registered ROM read with one cycle latency
    always @(posedge clk) begin
        mem_data <= rom[mem_addr[ADDR_W-1:2]];
    end

    // ========================================
    // stimulus helpers
    // ========================================
    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v          = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int switch_word();
        return (HEADER_BYTES + host_count * ENTRY_BYTES) / WORD_BYTES;
    endfunction

    task automatic build_rom();
        int sw;
        for (int a = 0; a < ROM_WORDS; a++) begin
            rom[a] = take_bits(32);
        end
        host_count = 1 + int'(take_bits(5)) % 20;
        max_sw     = 3 + int'(take_bits(3)) % 5;
        rom[0]     = HOST_MAGIC;
        rom[1]     = host_count;
        rom[2]     = '0;
        rom[3]     = '0;
        sw         = switch_word();
        rom[sw]    = SWITCH_MAGIC;
        rom[sw+1]  = (max_sw + 1) * (max_sw + 1);
        rom[sw+2]  = max_sw;
        rom[sw+3]  = '0;
    endtask

    // ========================================
    // reference model
    // ========================================
    // byte 0 of the low word lands in the top byte
    function automatic logic [47:0] mac_bytes(input logic [31:0] lo, input logic [31:0] hi);
        logic [63:0] pair;
        logic [47:0] m;
        pair = {hi, lo};
        m    = '0;
        for (int b = 0; b < 6; b++) begin
            m = {m[39:0], pair[8*b +: 8]};
        end
        return m;
    endfunction

    function automatic host_entry_t ref_host(input int idx);
        host_entry_t h;
        int          w;
        w           = (HEADER_BYTES + idx * ENTRY_BYTES) / WORD_BYTES;
        h.ip        = rom[w];
        h.switch_id = rom[w+1];
        h.port      = rom[w+2][15:0];
        h.qp        = rom[w+2][31:16];
        h.mac       = mac_bytes(rom[w+3], rom[w+4]);
        return h;
    endfunction

    function automatic path_entry_t ref_path(input int src, input int dst);
        path_entry_t p;
        int          w;
        w = switch_word() + HEADER_WORDS + (src * (max_sw + 1) + dst) * ENTRY_WORDS;
        p.route_valid   = rom[w][0];
        p.out_port      = rom[w+1][15:0];
        p.out_qp        = rom[w+1][31:16];
        p.next_hop_ip   = rom[w+2];
        p.next_hop_port = rom[w+3][15:0];
        p.next_hop_qp   = rom[w+3][31:16];
        p.next_hop_mac  = mac_bytes(rom[w+4], rom[w+5]);
        return p;
    endfunction

    // ========================================
    // handshake tasks
    // ========================================
    function automatic logic ack_of(input int which);
        case (which)
            ACK_LOAD: return load_ack;
            ACK_HOST: return host_ack;
            default:  return path_ack;
        endcase
    endfunction

    // n counts clock edges after the edge that drove the request
    task automatic wait_level(input int which, input logic level, input int limit,
                              input string what, output int n);
        n = 0;
        @(negedge clk);
        while (ack_of(which) !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (ack_of(which) !== level) begin
            $display("%s did not go to %0b within %0d cycles", what, level, limit);
            errors++;
        end
    endtask

    task automatic check_latency(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            $display("[FAIL] %s latency got 'h%h exp 'h%h", what, got, exp);
            errors++;
        end
    endtask

    task automatic run_load(input logic expect_ok);
        int n;
        @(posedge clk);
        load_req <= 1'b1;
        wait_level(ACK_LOAD, 1'b1, 2 * LOAD_CYC, "load_ack", n);
        check_latency("load_ack", n, 2 * (HEADER_WORDS + 2) + 3);
        checks++;
        if (tables_valid !== expect_ok || parse_error !== !expect_ok) begin
            $display("[FAIL] tables_valid/parse_error got 'h%h/'h%h exp 'h%h/'h%h",
                     tables_valid, parse_error, expect_ok, !expect_ok);
            errors++;
        end
        @(posedge clk);
        load_req <= 1'b0;
        wait_level(ACK_LOAD, 1'b0, 4, "load_ack", n);
    endtask

    task automatic host_query(input int idx);
        int   n;
        logic found;
        found = idx < host_count;
        exp_host_q.push_back(ref_host(idx));
        exp_found_q.push_back(found);
        @(posedge clk);
        host_index <= HOST_IDX_W'(idx);
        host_req   <= 1'b1;
        wait_level(ACK_HOST, 1'b1, 2 * QUERY_CYC, "host_ack", n);
        check_latency("host_ack", n, found ? ENTRY_WORDS + 4 : 2);
        @(posedge clk);
        host_req <= 1'b0;
        wait_level(ACK_HOST, 1'b0, 4, "host_ack", n);
    endtask

    task automatic path_query(input int src, input int dst);
        int n;
        exp_path_q.push_back(ref_path(src, dst));
        @(posedge clk);
        src_switch <= SWITCH_ID_W'(src);
        dst_switch <= SWITCH_ID_W'(dst);
        path_req   <= 1'b1;
        wait_level(ACK_PATH, 1'b1, 2 * QUERY_CYC, "path_ack", n);
        check_latency("path_ack", n, ENTRY_WORDS + 4);
        @(posedge clk);
        path_req <= 1'b0;
        wait_level(ACK_PATH, 1'b0, 4, "path_ack", n);
    endtask

    // both requests in one cycle and host goes first
    task automatic tie_query(input int idx, input int src, input int dst);
        int n;
        exp_host_q.push_back(ref_host(idx));
        exp_found_q.push_back(1'b1);
        exp_path_q.push_back(ref_path(src, dst));
        @(posedge clk);
        host_index <= HOST_IDX_W'(idx);
        src_switch <= SWITCH_ID_W'(src);
        dst_switch <= SWITCH_ID_W'(dst);
        host_req   <= 1'b1;
        path_req   <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!host_ack && !path_ack && n < 2 * QUERY_CYC);
        checks++;
        if (!host_ack) begin
            $display("host query was not answered first in a tie with a path query");
            errors++;
        end
        @(posedge clk);
        host_req <= 1'b0;
        wait_level(ACK_PATH, 1'b1, 3 * QUERY_CYC, "path_ack", n);
        @(posedge clk);
        path_req <= 1'b0;
        wait_level(ACK_PATH, 1'b0, 4, "path_ack", n);
    endtask

    // ========================================
    // compare process
    // ========================================
    always @(negedge clk) begin
        if (rst_n) begin
            if (host_ack && !host_ack_q) begin
                if (exp_host_q.size() == 0) begin
                    $display("host_ack rose with no host query outstanding");
                    errors++;
                end else begin
                    exp_h = exp_host_q.pop_front();
                    exp_f = exp_found_q.pop_front();
                    checks++;
                    if (host_found !== exp_f) begin
                        $display("[FAIL] host_found got 'h%h exp 'h%h", host_found, exp_f);
                        errors++;
                    end else if (exp_f && host_entry !== exp_h) begin
                        $display("[FAIL] host_entry got 'h%h exp 'h%h", host_entry, exp_h);
                        errors++;
                    end
                end
            end
            if (path_ack && !path_ack_q) begin
                if (exp_path_q.size() == 0) begin
                    $display("path_ack rose with no path query outstanding");
                    errors++;
                end else begin
                    exp_p = exp_path_q.pop_front();
                    checks++;
                    if (path_entry !== exp_p) begin
                        $display("[FAIL] path_entry got 'h%h exp 'h%h", path_entry, exp_p);
                        errors++;
                    end
                end
            end
        end
        host_ack_q = host_ack;
        path_ack_q = path_ack;
    end

    // ========================================
    // main sequence
    // ========================================
    initial begin
        int  sw;
        logic seen;
        rst_n      = 1'b0;
        mem_data   = '0;
        load_req   = 1'b0;
        host_req   = 1'b0;
        host_index = '0;
        path_req   = 1'b0;
        src_switch = '0;
        dst_switch = '0;
        host_ack_q = 1'b0;
        path_ack_q = 1'b0;
        errors     = 0;
        checks     = 0;
        lfsr_state = 32'hdd4e3b02;
        build_rom();

        @(negedge clk);
        checks++;
        if (load_ack !== 1'b0 || tables_valid !== 1'b0 || parse_error !== 1'b0
            || host_ack !== 1'b0 || path_ack !== 1'b0 || mem_addr !== '0) begin
            $display("outputs are not all cleared during reset");
            errors++;
        end
        repeat (7) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        run_load(1'b1);
        for (int i = 0; i < host_count; i++) begin
            host_query(i);
        end
        host_query(host_count);
        host_query((1 << HOST_IDX_W) - 1);
        for (int k = 0; k < N_PATHS; k++) begin
            path_query(int'(take_bits(3)) % (max_sw + 1), int'(take_bits(3)) % (max_sw + 1));
        end
        tie_query(host_count - 1, max_sw, 0);

        // broken switch magic holds queries off
        sw      = switch_word();
        rom[sw] = SWITCH_MAGIC ^ 32'h1;
        run_load(1'b0);
        @(posedge clk);
        host_index <= '0;
        host_req   <= 1'b1;
        seen = 1'b0;
        repeat (ENTRY_WORDS + 6) begin
            @(negedge clk);
            seen = seen | host_ack;
        end
        checks++;
        if (seen) begin
            $display("host query was answered while the tables were not valid");
            errors++;
        end
        @(posedge clk);
        host_req <= 1'b0;

        rom[sw] = SWITCH_MAGIC;
        run_load(1'b1);
        host_query(0);
        repeat (4) @(posedge clk);

        if (exp_host_q.size() != 0 || exp_path_q.size() != 0) begin
            $display("some queries never received an ack");
            errors++;
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYC) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles without finishing", TIMEOUT_CYC);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: verilog/burst_reader.sv
`timescale 1ns/100ps

module burst_reader
    import routing_pkg::*;
#(
    parameter int  ADDR_W    = 16,
    parameter type payload_t = word_t
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rd_start,
    input  logic [ADDR_W-1:0] base_addr,
    input  logic [WORD_W-1:0] mem_data,
    output logic [ADDR_W-1:0] rd_addr,
    output logic              rd_done,
    output payload_t          payload
);

    localparam int WORDS = $bits(payload_t) / WORD_W;
    localparam int CNT_W = $clog2(WORDS + 1);

    logic [CNT_W-1:0]             iss_cnt;
    logic                         addr_vld;
    logic                         addr_last;
    logic                         data_vld;
    logic                         data_last;
    logic [WORDS-1:0][WORD_W-1:0] words_q;

    assign addr_last = addr_vld && (iss_cnt == CNT_W'(WORDS - 1));

    // address side, one word per cycle, ROM answers a cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr   <= '0;
            iss_cnt   <= '0;
            addr_vld  <= 1'b0;
            data_vld  <= 1'b0;
            data_last <= 1'b0;
            rd_done   <= 1'b0;
        end else begin
            data_vld  <= addr_vld;
            data_last <= addr_last;
            rd_done   <= data_vld && data_last;
            if (rd_start) begin
                rd_addr  <= base_addr;
                iss_cnt  <= '0;
                addr_vld <= 1'b1;
            end else if (addr_vld) begin
                if (addr_last) begin
                    // last address stays on the bus
                    addr_vld <= 1'b0;
                end else begin
                    rd_addr <= rd_addr + ADDR_W'(WORD_BYTES);
                    iss_cnt <= iss_cnt + 1'b1;
                end
            end
        end
    end

    // shift down so word 0 ends in slot 0
    always_ff @(posedge clk) begin
        if (data_vld) begin
            words_q[WORDS-1] <= mem_data;
            for (int i = 0; i < WORDS - 1; i++) begin
                words_q[i] <= words_q[i+1];
            end
        end
    end

    assign payload = payload_t'(words_q);

endmodule

// File: verilog/lookup_engine.sv
`timescale 1ns/100ps

module lookup_engine
    import routing_pkg::*;
#(
    parameter int ADDR_W      = 16,
    parameter int HOST_IDX_W  = 6,
    parameter int SWITCH_ID_W = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  table_info_t            info,
    input  logic                   tables_valid,
    input  logic [ADDR_W-1:0]      loader_addr,
    input  logic [WORD_W-1:0]      mem_data,
    output logic [ADDR_W-1:0]      mem_addr,
    input  logic                   host_req,
    input  logic [HOST_IDX_W-1:0]  host_index,
    output logic                   host_ack,
    output logic                   host_found,
    output host_entry_t            host_entry,
    input  logic                   path_req,
    input  logic [SWITCH_ID_W-1:0] src_switch,
    input  logic [SWITCH_ID_W-1:0] dst_switch,
    output logic                   path_ack,
    output path_entry_t            path_entry
);

    typedef enum logic [1:0] {E_IDLE, E_CHECK, E_READ, E_ACK} eng_state_t;

    eng_state_t             state;
    logic                   sel_host;
    logic [HOST_IDX_W-1:0]  idx_q;
    logic [SWITCH_ID_W-1:0] src_q;
    logic [SWITCH_ID_W-1:0] dst_q;
    logic                   host_in_range;
    word_t                  host_addr;
    word_t                  path_addr;
    word_t                  entry_addr;
    logic                   rd_start;
    logic                   rd_done;
    logic [ADDR_W-1:0]      rd_addr;
    entry_words_t           raw;

    // MAC bytes come out of the ROM little-end first
    function automatic mac_t swap_mac(input word_t lo, input word_t hi);
        return {lo[7:0], lo[15:8], lo[23:16], lo[31:24], hi[7:0], hi[15:8]};
    endfunction

    function automatic host_entry_t decode_host(input entry_words_t w);
        host_entry_t h;
        h.ip        = w[0];
        h.switch_id = w[1];
        h.port      = w[2][15:0];
        h.qp        = w[2][31:16];
        h.mac       = swap_mac(w[3], w[4]);
        return h;
    endfunction

    function automatic path_entry_t decode_path(input entry_words_t w);
        path_entry_t p;
        p.route_valid   = w[0][0];
        p.out_port      = w[1][15:0];
        p.out_qp        = w[1][31:16];
        p.next_hop_ip   = w[2];
        p.next_hop_port = w[3][15:0];
        p.next_hop_qp   = w[3][31:16];
        p.next_hop_mac  = swap_mac(w[4], w[5]);
        return p;
    endfunction

    // ========================================
    // entry addressing
    // ========================================
    assign host_in_range = WORD_W'(idx_q) < info.host_count;
    assign host_addr     = WORD_W'(HEADER_BYTES) + WORD_W'(idx_q) * WORD_W'(ENTRY_BYTES);
    // row major, max_switch_id + 1 destinations per source
    assign path_addr  = info.switch_base + WORD_W'(HEADER_BYTES)
                      + (WORD_W'(src_q) * (info.max_switch_id + 1) + WORD_W'(dst_q))
                      * WORD_W'(ENTRY_BYTES);
    assign entry_addr = sel_host ? host_addr : path_addr;

    assign rd_start = (state == E_CHECK) && !(sel_host && !host_in_range);

    // loader owns the ROM until the tables are up
    assign mem_addr = tables_valid ? rd_addr : loader_addr;

    burst_reader #(
        .ADDR_W    (ADDR_W),
        .payload_t (entry_words_t)
    ) u_entry_reader (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_start  (rd_start),
        .base_addr (entry_addr[ADDR_W-1:0]),
        .mem_data  (mem_data),
        .rd_addr   (rd_addr),
        .rd_done   (rd_done),
        .payload   (raw)
    );

    // ========================================
    // query FSM, host wins a tie
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= E_IDLE;
            sel_host   <= 1'b0;
            idx_q      <= '0;
            src_q      <= '0;
            dst_q      <= '0;
            host_ack   <= 1'b0;
            host_found <= 1'b0;
            path_ack   <= 1'b0;
        end else begin
            case (state)
                E_IDLE: begin
                    if (tables_valid && host_req) begin
                        sel_host <= 1'b1;
                        idx_q    <= host_index;
                        state    <= E_CHECK;
                    end else if (tables_valid && path_req) begin
                        sel_host <= 1'b0;
                        src_q    <= src_switch;
                        dst_q    <= dst_switch;
                        state    <= E_CHECK;
                    end
                end
                E_CHECK: begin
                    if (sel_host && !host_in_range) begin
                        // no ROM access for a missing host
                        host_found <= 1'b0;
                        host_ack   <= 1'b1;
                        state      <= E_ACK;
                    end else begin
                        state <= E_READ;
                    end
                end
                E_READ: begin
                    if (rd_done) begin
                        host_found <= sel_host;
                        host_ack   <= sel_host;
                        path_ack   <= !sel_host;
                        state      <= E_ACK;
                    end
                end
                E_ACK: begin
                    if (sel_host && !host_req) begin
                        host_ack <= 1'b0;
                        state    <= E_IDLE;
                    end else if (!sel_host && !path_req) begin
                        path_ack <= 1'b0;
                        state    <= E_IDLE;
                    end
                end
                default: state <= E_IDLE;
            endcase
        end
    end

    // decoded results held until the next read of the same kind
    always_ff @(posedge clk) begin
        if (state == E_READ && rd_done) begin
            if (sel_host) begin
                host_entry <= decode_host(raw);
            end else begin
                path_entry <= decode_path(raw);
            end
        end
    end

endmodule

// File: verilog/routing_pkg.sv
package routing_pkg;

    // ========================================
    // ROM word geometry
    // ========================================
    localparam int WORD_W     = 32;
    localparam int WORD_BYTES = WORD_W / 8;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [47:0]       mac_t;

    // ========================================
    // table layout
    // ========================================
    // both tables start with a 4-word header
    localparam int HEADER_WORDS = 4;
    // host and path entries share one size
    localparam int ENTRY_WORDS  = 6;

    localparam int HEADER_BYTES = HEADER_WORDS * WORD_BYTES;
    localparam int ENTRY_BYTES  = ENTRY_WORDS * WORD_BYTES;

    // ASCII "HOST" and "SWCH"
    localparam word_t HOST_MAGIC   = 32'h484F5354;
    localparam word_t SWITCH_MAGIC = 32'h53574348;

    // raw header, word 0 magic, 1 count, 2 max switch id, 3 unused
    typedef word_t [HEADER_WORDS-1:0] header_words_t;

    // raw entry as read from the ROM
    typedef word_t [ENTRY_WORDS-1:0] entry_words_t;

    // what the lookups need once both headers are parsed
    typedef struct packed {
        word_t host_count;
        word_t max_switch_id;
        // byte address of the switch path header
        word_t switch_base;
    } table_info_t;

    // ========================================
    // decoded entries
    // ========================================
    typedef struct packed {
        word_t       ip;
        word_t       switch_id;
        logic [15:0] port;
        logic [15:0] qp;
        mac_t        mac;
    } host_entry_t;

    typedef struct packed {
        logic        route_valid;
        logic [15:0] out_port;
        logic [15:0] out_qp;
        word_t       next_hop_ip;
        logic [15:0] next_hop_port;
        logic [15:0] next_hop_qp;
        mac_t        next_hop_mac;
    } path_entry_t;

endpackage

// File: verilog/routing_table_reader.sv
`timescale 1ns/100ps

module routing_table_reader
    import routing_pkg::*;
#(
    parameter int ADDR_W      = 16,
    parameter int HOST_IDX_W  = 6,
    parameter int SWITCH_ID_W = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    // ROM port
    output logic [ADDR_W-1:0]      mem_addr,
    input  logic [WORD_W-1:0]      mem_data,
    // load handshake
    input  logic                   load_req,
    output logic                   load_ack,
    output logic                   tables_valid,
    output logic                   parse_error,
    // host query
    input  logic                   host_req,
    input  logic [HOST_IDX_W-1:0]  host_index,
    output logic                   host_ack,
    output logic                   host_found,
    output host_entry_t            host_entry,
    // path query
    input  logic                   path_req,
    input  logic [SWITCH_ID_W-1:0] src_switch,
    input  logic [SWITCH_ID_W-1:0] dst_switch,
    output logic                   path_ack,
    output path_entry_t            path_entry
);

    table_info_t       info;
    logic [ADDR_W-1:0] loader_addr;

    table_loader #(
        .ADDR_W (ADDR_W)
    ) u_loader (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_req     (load_req),
        .mem_data     (mem_data),
        .load_ack     (load_ack),
        .tables_valid (tables_valid),
        .parse_error  (parse_error),
        .loader_addr  (loader_addr),
        .info         (info)
    );

    lookup_engine #(
        .ADDR_W      (ADDR_W),
        .HOST_IDX_W  (HOST_IDX_W),
        .SWITCH_ID_W (SWITCH_ID_W)
    ) u_engine (
        .clk          (clk),
        .rst_n        (rst_n),
        .info         (info),
        .tables_valid (tables_valid),
        .loader_addr  (loader_addr),
        .mem_data     (mem_data),
        .mem_addr     (mem_addr),
        .host_req     (host_req),
        .host_index   (host_index),
        .host_ack     (host_ack),
        .host_found   (host_found),
        .host_entry   (host_entry),
        .path_req     (path_req),
        .src_switch   (src_switch),
        .dst_switch   (dst_switch),
        .path_ack     (path_ack),
        .path_entry   (path_entry)
    );

endmodule

// File: verilog/table_loader.sv
`timescale 1ns/100ps

module table_loader
    import routing_pkg::*;
#(
    parameter int ADDR_W = 16
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load_req,
    input  logic [WORD_W-1:0] mem_data,
    output logic              load_ack,
    output logic              tables_valid,
    output logic              parse_error,
    output logic [ADDR_W-1:0] loader_addr,
    output table_info_t       info
);

    typedef enum logic [2:0] {
        L_IDLE,
        L_HOST_HDR,
        L_SW_BASE,
        L_SW_START,
        L_SW_HDR,
        L_DONE
    } load_state_t;

    load_state_t       state;
    logic              rd_start;
    logic              rd_done;
    logic [ADDR_W-1:0] base_addr;
    header_words_t     hdr;

    // host header always sits at address 0
    assign rd_start  = (state == L_IDLE && load_req) || (state == L_SW_START);
    assign base_addr = (state == L_SW_START) ? info.switch_base[ADDR_W-1:0] : '0;

    burst_reader #(
        .ADDR_W    (ADDR_W),
        .payload_t (header_words_t)
    ) u_hdr_reader (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_start  (rd_start),
        .base_addr (base_addr),
        .mem_data  (mem_data),
        .rd_addr   (loader_addr),
        .rd_done   (rd_done),
        .payload   (hdr)
    );

    // ========================================
    // load sequence
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= L_IDLE;
            load_ack     <= 1'b0;
            tables_valid <= 1'b0;
            parse_error  <= 1'b0;
            info         <= '0;
        end else begin
            case (state)
                L_IDLE: begin
                    if (load_req) begin
                        tables_valid <= 1'b0;
                        parse_error  <= 1'b0;
                        state        <= L_HOST_HDR;
                    end
                end
                L_HOST_HDR: begin
                    if (rd_done) begin
                        if (hdr[0] == HOST_MAGIC) begin
                            info.host_count <= hdr[1];
                            state           <= L_SW_BASE;
                        end else begin
                            // switch header is never fetched
                            parse_error <= 1'b1;
                            load_ack    <= 1'b1;
                            state       <= L_DONE;
                        end
                    end
                end
                L_SW_BASE: begin
                    // switch table follows the last host entry
                    info.switch_base <= WORD_W'(HEADER_BYTES)
                                      + info.host_count * WORD_W'(ENTRY_BYTES);
                    state            <= L_SW_START;
                end
                L_SW_START: begin
                    state <= L_SW_HDR;
                end
                L_SW_HDR: begin
                    if (rd_done) begin
                        if (hdr[0] == SWITCH_MAGIC) begin
                            info.max_switch_id <= hdr[2];
                            tables_valid       <= 1'b1;
                        end else begin
                            parse_error <= 1'b1;
                        end
                        load_ack <= 1'b1;
                        state    <= L_DONE;
                    end
                end
                L_DONE: begin
                    if (!load_req) begin
                        load_ack <= 1'b0;
                        state    <= L_IDLE;
                    end
                end
                default: state <= L_IDLE;
            endcase
        end
    end

endmodule
